// ==== verilog/mmu_pkg.sv ====
package mmu_pkg;

    // Bus and address widths.
    localparam int RW         = 16;
    localparam int IN_ADDR_W  = 16;
    localparam int OUT_ADDR_W = 24;

    // Page geometry.
    localparam int OFF_W        = 11;
    localparam int PAGE_IDX_W   = 4;
    localparam int PAGE_ENTRIES = 16;
    localparam int PAGE_RES_W   = 13;

    // Prefix placed above the virtual address when paging is off.
    localparam logic [7:0] PAGE_DEFAULT_PREFIX = 8'h10;

    // Cacheable window with an inclusive low bound and an exclusive high bound.
    localparam logic [OUT_ADDR_W-1:0] CACHE_LO = 24'h104008;
    localparam logic [OUT_ADDR_W-1:0] CACHE_HI = 24'h800000;

    // Page table windows on the system-register bus.
    localparam logic [RW-1:0] SR_IMMU_BASE = 16'h0220;
    localparam logic [RW-1:0] SR_DMMU_BASE = 16'h0200;

    // Queue depth sets the sender credits after reset.
    localparam int FIFO_DEPTH  = 4;
    localparam int MEM_CREDITS = 2;

    typedef logic [IN_ADDR_W-1:0]  vaddr_t;
    typedef logic [OUT_ADDR_W-1:0] paddr_t;

    // Instruction fetch request.
    typedef struct packed {
        vaddr_t addr;
    } fetch_req_t;

    // Data access request.
    typedef struct packed {
        vaddr_t          addr;
        logic            we;
        logic [RW-1:0]   wdata;
    } data_req_t;

endpackage

// ==== verilog/credit_fifo.sv ====
`timescale 1ns/100ps

module credit_fifo
    import mmu_pkg::*;
#(
    parameter type payload_t = fetch_req_t,
    parameter int  DEPTH     = FIFO_DEPTH
) (
    input  logic     i_clk,
    input  logic     i_rst,

    input  logic     i_push,
    input  payload_t i_data,

    input  logic     i_pop,
    output logic     o_valid,
    output payload_t o_data,

    output logic     o_credit
);

    localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;

    payload_t        mem [DEPTH];
    logic [AW-1:0]   wr_ptr;
    logic [AW-1:0]   rd_ptr;
    logic [AW:0]     count;

    logic            do_push;
    logic            do_pop;
    logic            full;

    assign full    = (count == (AW+1)'(DEPTH));
    assign o_valid = (count != '0);
    assign o_data  = mem[rd_ptr];

    assign do_push = i_push;
    assign do_pop  = i_pop & o_valid;

    // Storage array.
    always_ff @(posedge i_clk) begin
        if (do_push) begin
            mem[wr_ptr] <= i_data;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= '0;
            o_credit <= 1'b0;
        end else begin
            if (do_push) begin
                wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
            // One credit back to the sender per released entry.
            o_credit <= do_pop;
        end
    end

    // Sender must hold a credit for every push.
    a_no_push_full: assert property (
        @(posedge i_clk) disable iff (i_rst)
        i_push |-> !full
    ) else $error("credit_fifo: push while full");

    // Arbiter pops only a valid head.
    a_no_pop_empty: assert property (
        @(posedge i_clk) disable iff (i_rst)
        i_pop |-> o_valid
    ) else $error("credit_fifo: pop while empty");

endmodule

// ==== verilog/page_mmu.sv ====
`timescale 1ns/100ps

module page_mmu
    import mmu_pkg::*;
#(
    parameter logic [RW-1:0] SR_BASE = SR_DMMU_BASE
) (
    input  logic          i_clk,
    input  logic          i_rst,

    input  vaddr_t        i_vaddr,
    input  logic          i_pag_en,

    input  logic [RW-1:0] i_sr_addr,
    input  logic [RW-1:0] i_sr_data,
    input  logic          i_sr_we,

    output paddr_t        o_paddr,
    output logic          o_cacheable
);

    logic [PAGE_RES_W-1:0] page_table [PAGE_ENTRIES];

    logic [OFF_W-1:0]      page_off;
    logic [PAGE_IDX_W-1:0] page_idx;
    logic [PAGE_RES_W-1:0] page_res;

    logic [RW-1:0]         sr_offset;
    logic                  sr_hit;

    paddr_t                paged_addr;
    paddr_t                flat_addr;
    paddr_t                paddr;

    // Split of the virtual address.
    assign page_off = i_vaddr[OFF_W-1:0];
    assign page_idx = i_vaddr[OFF_W+PAGE_IDX_W-1:OFF_W];
    assign page_res = page_table[page_idx];

    // Window decode on the system-register bus.
    assign sr_offset = i_sr_addr - SR_BASE;
    assign sr_hit    = (i_sr_addr >= SR_BASE) &&
                       (i_sr_addr < SR_BASE + RW'(PAGE_ENTRIES));

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            for (int i = 0; i < PAGE_ENTRIES; i++) begin
                page_table[i] <= '0;
            end
        end else if (i_sr_we && sr_hit) begin
            page_table[sr_offset[PAGE_IDX_W-1:0]] <= i_sr_data[PAGE_RES_W-1:0];
        end
    end

    // Entry above the offset when paged.
    assign paged_addr = {page_res, page_off};

    // Fixed prefix above the whole virtual address otherwise.
    assign flat_addr = {PAGE_DEFAULT_PREFIX, i_vaddr};

    always_comb begin
        if (i_pag_en) begin
            paddr = paged_addr;
        end else begin
            paddr = flat_addr;
        end
    end

    assign o_paddr     = paddr;
    assign o_cacheable = (paddr >= CACHE_LO) && (paddr < CACHE_HI);

endmodule

// ==== verilog/mem_arbiter.sv ====
`timescale 1ns/100ps

module mem_arbiter
    import mmu_pkg::*;
(
    input  logic          i_clk,
    input  logic          i_rst,

    // Translated fetch queue head.
    input  logic          i_if_valid,
    input  paddr_t        i_if_paddr,
    input  logic          i_if_cacheable,

    // Translated data queue head.
    input  logic          i_d_valid,
    input  data_req_t     i_d_req,
    input  paddr_t        i_d_paddr,
    input  logic          i_d_cacheable,

    input  logic          i_mem_credit,

    output logic          o_if_pop,
    output logic          o_d_pop,

    output logic          o_mem_valid,
    output paddr_t        o_mem_addr,
    output logic          o_mem_is_fetch,
    output logic          o_mem_we,
    output logic [RW-1:0] o_mem_wdata,
    output logic          o_mem_cacheable
);

    localparam int CW = $clog2(MEM_CREDITS + 1);

    logic [CW-1:0] credits;
    logic          has_credit;
    logic          last_d;
    logic          grant_if;
    logic          grant_d;
    logic          issue;

    assign has_credit = (credits != '0);

    // The stream not served last wins a tie.
    assign grant_if = has_credit && i_if_valid && (!i_d_valid || last_d);
    assign grant_d  = has_credit && i_d_valid && (!i_if_valid || !last_d);
    assign issue    = grant_if || grant_d;

    assign o_if_pop = grant_if;
    assign o_d_pop  = grant_d;

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            credits     <= CW'(MEM_CREDITS);
            last_d      <= 1'b0;
            o_mem_valid <= 1'b0;
        end else begin
            case ({i_mem_credit, issue})
                2'b10:   credits <= credits + 1'b1;
                2'b01:   credits <= credits - 1'b1;
                default: credits <= credits;
            endcase
            if (issue) begin
                last_d <= grant_d;
            end
            o_mem_valid <= issue;
        end
    end

    // Payload registers follow the grant.
    always_ff @(posedge i_clk) begin
        if (grant_d) begin
            o_mem_addr      <= i_d_paddr;
            o_mem_is_fetch  <= 1'b0;
            o_mem_we        <= i_d_req.we;
            o_mem_wdata     <= i_d_req.wdata;
            o_mem_cacheable <= i_d_cacheable;
        end else if (grant_if) begin
            o_mem_addr      <= i_if_paddr;
            o_mem_is_fetch  <= 1'b1;
            o_mem_we        <= 1'b0;
            o_mem_wdata     <= '0;
            o_mem_cacheable <= i_if_cacheable;
        end
    end

    // Memory side never returns more credits than it was given.
    a_credit_bound: assert property (
        @(posedge i_clk) disable iff (i_rst)
        credits <= CW'(MEM_CREDITS)
    ) else $error("mem_arbiter: memory credit overflow");

endmodule

// ==== verilog/mmu_top.sv ====
`timescale 1ns/100ps

module mmu_top
    import mmu_pkg::*;
(
    input  logic          i_clk,
    input  logic          i_rst,

    // Instruction fetch channel.
    input  logic          i_if_valid,
    input  vaddr_t        i_if_addr,
    output logic          o_if_credit,

    // Data channel.
    input  logic          i_d_valid,
    input  vaddr_t        i_d_addr,
    input  logic          i_d_we,
    input  logic [RW-1:0] i_d_wdata,
    output logic          o_d_credit,

    // System-register write bus.
    input  logic [RW-1:0] i_sr_addr,
    input  logic [RW-1:0] i_sr_data,
    input  logic          i_sr_we,
    input  logic          i_pag_en,

    // Memory port.
    output logic          o_mem_valid,
    output paddr_t        o_mem_addr,
    output logic          o_mem_is_fetch,
    output logic          o_mem_we,
    output logic [RW-1:0] o_mem_wdata,
    output logic          o_mem_cacheable,
    input  logic          i_mem_credit
);

    fetch_req_t if_req;
    data_req_t  d_req;

    logic       if_valid;
    fetch_req_t if_head;
    logic       if_pop;
    paddr_t     if_paddr;
    logic       if_cacheable;

    logic       d_valid;
    data_req_t  d_head;
    logic       d_pop;
    paddr_t     d_paddr;
    logic       d_cacheable;

    assign if_req = '{addr: i_if_addr};
    assign d_req  = '{addr: i_d_addr, we: i_d_we, wdata: i_d_wdata};

    credit_fifo #(.payload_t(fetch_req_t), .DEPTH(FIFO_DEPTH)) u_if_fifo (
        .i_clk   (i_clk),
        .i_rst   (i_rst),
        .i_push  (i_if_valid),
        .i_data  (if_req),
        .i_pop   (if_pop),
        .o_valid (if_valid),
        .o_data  (if_head),
        .o_credit(o_if_credit)
    );

    credit_fifo #(.payload_t(data_req_t), .DEPTH(FIFO_DEPTH)) u_d_fifo (
        .i_clk   (i_clk),
        .i_rst   (i_rst),
        .i_push  (i_d_valid),
        .i_data  (d_req),
        .i_pop   (d_pop),
        .o_valid (d_valid),
        .o_data  (d_head),
        .o_credit(o_d_credit)
    );

    page_mmu #(.SR_BASE(SR_IMMU_BASE)) u_immu (
        .i_clk      (i_clk),
        .i_rst      (i_rst),
        .i_vaddr    (if_head.addr),
        .i_pag_en   (i_pag_en),
        .i_sr_addr  (i_sr_addr),
        .i_sr_data  (i_sr_data),
        .i_sr_we    (i_sr_we),
        .o_paddr    (if_paddr),
        .o_cacheable(if_cacheable)
    );

    page_mmu #(.SR_BASE(SR_DMMU_BASE)) u_dmmu (
        .i_clk      (i_clk),
        .i_rst      (i_rst),
        .i_vaddr    (d_head.addr),
        .i_pag_en   (i_pag_en),
        .i_sr_addr  (i_sr_addr),
        .i_sr_data  (i_sr_data),
        .i_sr_we    (i_sr_we),
        .o_paddr    (d_paddr),
        .o_cacheable(d_cacheable)
    );

    mem_arbiter u_arb (
        .i_clk          (i_clk),
        .i_rst          (i_rst),
        .i_if_valid     (if_valid),
        .i_if_paddr     (if_paddr),
        .i_if_cacheable (if_cacheable),
        .i_d_valid      (d_valid),
        .i_d_req        (d_head),
        .i_d_paddr      (d_paddr),
        .i_d_cacheable  (d_cacheable),
        .i_mem_credit   (i_mem_credit),
        .o_if_pop       (if_pop),
        .o_d_pop        (d_pop),
        .o_mem_valid    (o_mem_valid),
        .o_mem_addr     (o_mem_addr),
        .o_mem_is_fetch (o_mem_is_fetch),
        .o_mem_we       (o_mem_we),
        .o_mem_wdata    (o_mem_wdata),
        .o_mem_cacheable(o_mem_cacheable)
    );

endmodule

// ==== dv/tb_mmu_cases.svh ====
// System-register writes that load both page tables.
// Columns are address and data.
localparam int N_SR = 10;

sr_write_t sr_writes [N_SR] = '{
    '{16'h0220, 16'h1000},
    '{16'h0223, 16'h0FFF},
    '{16'h022F, 16'hE208},
    '{16'h0200, 16'h0AAA},
    '{16'h0203, 16'h1555},
    '{16'h020F, 16'h0209},
    // Writes outside both windows that must not land anywhere.
    '{16'h0210, 16'h1FFF},
    '{16'h0230, 16'h1FFF},
    '{16'h01FF, 16'h1FFF},
    '{16'h021F, 16'h1FFF}
};

// Requests in order. The tables are loaded just before entry LOAD_AT.
// Columns are is_fetch, vaddr, we, wdata, pag_en,
// expected paddr and expected cacheable.
localparam int N_REQ   = 25;
localparam int LOAD_AT = 8;

req_case_t req_cases [N_REQ] = '{
    '{1'b1, 16'h1234, 1'b0, 16'h0000, 1'b1, 24'h000234, 1'b0},
    '{1'b0, 16'hFFFF, 1'b1, 16'h1111, 1'b1, 24'h0007FF, 1'b0},
    '{1'b1, 16'h0000, 1'b0, 16'h0000, 1'b0, 24'h100000, 1'b0},
    '{1'b1, 16'h4007, 1'b0, 16'h0000, 1'b0, 24'h104007, 1'b0},
    '{1'b0, 16'h4008, 1'b1, 16'hBEEF, 1'b0, 24'h104008, 1'b1},
    '{1'b0, 16'hFFFF, 1'b0, 16'h0000, 1'b0, 24'h10FFFF, 1'b1},
    '{1'b1, 16'hC3A5, 1'b0, 16'h0000, 1'b0, 24'h10C3A5, 1'b1},
    '{1'b0, 16'h2000, 1'b1, 16'h1357, 1'b0, 24'h102000, 1'b0},
    '{1'b1, 16'h0000, 1'b0, 16'h0000, 1'b1, 24'h800000, 1'b0},
    '{1'b0, 16'h0000, 1'b1, 16'hA5A5, 1'b1, 24'h555000, 1'b1},
    '{1'b1, 16'h1FFF, 1'b0, 16'h0000, 1'b1, 24'h7FFFFF, 1'b1},
    '{1'b0, 16'h1FFF, 1'b0, 16'h0000, 1'b1, 24'hAAAFFF, 1'b0},
    '{1'b1, 16'h7808, 1'b0, 16'h0000, 1'b1, 24'h104008, 1'b1},
    '{1'b1, 16'h7807, 1'b0, 16'h0000, 1'b1, 24'h104007, 1'b0},
    '{1'b0, 16'hF807, 1'b1, 16'h5A5A, 1'b1, 24'h104807, 1'b1},
    '{1'b0, 16'h0ABC, 1'b0, 16'h0000, 1'b1, 24'h0002BC, 1'b0},
    '{1'b0, 16'h1800, 1'b1, 16'h0001, 1'b1, 24'hAAA800, 1'b0},
    '{1'b0, 16'h1801, 1'b1, 16'h0002, 1'b1, 24'hAAA801, 1'b0},
    '{1'b0, 16'h0001, 1'b1, 16'h0003, 1'b1, 24'h555001, 1'b1},
    '{1'b0, 16'h0002, 1'b0, 16'h0000, 1'b1, 24'h555002, 1'b1},
    '{1'b0, 16'h7FFF, 1'b1, 16'hFFFF, 1'b1, 24'h104FFF, 1'b1},
    '{1'b1, 16'h1800, 1'b0, 16'h0000, 1'b1, 24'h7FF800, 1'b1},
    '{1'b1, 16'h1000, 1'b0, 16'h0000, 1'b1, 24'h000000, 1'b0},
    '{1'b1, 16'h0FFF, 1'b0, 16'h0000, 1'b1, 24'h0007FF, 1'b0},
    '{1'b1, 16'h0123, 1'b0, 16'h0000, 1'b1, 24'h800123, 1'b0}
};

// ==== dv/tb_mmu_top.sv ====
`timescale 1ns/100ps

module tb_mmu_top
    import mmu_pkg::*;
();

    localparam logic [31:0] SEED         = 32'hc622_0257;
    localparam int          CLK_PERIOD   = 100;
    localparam int          RESET_CYCLES = 8;

    typedef struct packed {
        logic [RW-1:0] addr;
        logic [RW-1:0] data;
    } sr_write_t;

    typedef struct packed {
        logic          is_fetch;
        vaddr_t        vaddr;
        logic          we;
        logic [RW-1:0] wdata;
        logic          pag_en;
        paddr_t        exp_paddr;
        logic          exp_cacheable;
    } req_case_t;

    `include "tb_mmu_cases.svh"

    localparam int TIMEOUT_CYCLES = 40 * (N_REQ + N_SR) + 200;

    logic          i_clk;
    logic          i_rst;
    logic          i_if_valid;
    vaddr_t        i_if_addr;
    logic          o_if_credit;
    logic          i_d_valid;
    vaddr_t        i_d_addr;
    logic          i_d_we;
    logic [RW-1:0] i_d_wdata;
    logic          o_d_credit;
    logic [RW-1:0] i_sr_addr;
    logic [RW-1:0] i_sr_data;
    logic          i_sr_we;
    logic          i_pag_en;
    logic          o_mem_valid;
    paddr_t        o_mem_addr;
    logic          o_mem_is_fetch;
    logic          o_mem_we;
    logic [RW-1:0] o_mem_wdata;
    logic          o_mem_cacheable;
    logic          i_mem_credit = 1'b0;

    int            if_credits  = FIFO_DEPTH;
    int            d_credits   = FIFO_DEPTH;
    int            mem_credits = MEM_CREDITS;
    int            cycles      = 0;
    int            credit_due [$];
    req_case_t     if_exp_q [$];
    req_case_t     d_exp_q [$];

    mmu_top DUT (.*);

    initial begin
        i_clk = 1'b0;
        forever begin
            #(CLK_PERIOD / 2) i_clk = ~i_clk;
        end
    end

    task automatic stop_run(input string why);
        $display("%s", why);
        $display("Something failed");
        $fatal(1, "run stopped");
    endtask

    task automatic check_paddr(input paddr_t got, input paddr_t want, input string what);
        if (got !== want) begin
            stop_run($sformatf("[ERROR] %0d ns: %s is %h, expected %h",
                               $time, what, got, want));
        end
    endtask

    task automatic check_bit(input logic got, input logic want, input string what);
        if (got !== want) begin
            stop_run($sformatf("[ERROR] %0d ns: %s is %b, expected %b",
                               $time, what, got, want));
        end
    endtask

    task automatic check_word(input logic [RW-1:0] got, input logic [RW-1:0] want,
                              input string what);
        if (got !== want) begin
            stop_run($sformatf("[ERROR] %0d ns: %s is %h, expected %h",
                               $time, what, got, want));
        end
    endtask

    // Every rising edge drops the strobes unless a caller drives them again.
    task automatic next_edge();
        @(posedge i_clk);
        i_if_valid <= 1'b0;
        i_d_valid  <= 1'b0;
        i_sr_we    <= 1'b0;
    endtask

    task automatic send_req(input req_case_t c);
        next_edge();
        while ((c.is_fetch && if_credits == 0) || (!c.is_fetch && d_credits == 0)) begin
            next_edge();
        end
        if (c.is_fetch) begin
            i_if_valid <= 1'b1;
            i_if_addr  <= c.vaddr;
            if_credits--;
            if_exp_q.push_back(c);
        end else begin
            i_d_valid <= 1'b1;
            i_d_addr  <= c.vaddr;
            i_d_we    <= c.we;
            i_d_wdata <= c.wdata;
            d_credits--;
            d_exp_q.push_back(c);
        end
    endtask

    task automatic write_sr(input sr_write_t w);
        next_edge();
        i_sr_addr <= w.addr;
        i_sr_data <= w.data;
        i_sr_we   <= 1'b1;
    endtask

    task automatic drain();
        while (if_exp_q.size() != 0 || d_exp_q.size() != 0) begin
            next_edge();
        end
    endtask

    task automatic settle();
        drain();
        while (credit_due.size() != 0) begin
            next_edge();
        end
        // The last memory credit pulse is counted at the falling edge before this one.
        next_edge();
    endtask

    // Cycle count, timeout and the memory side returning credits.
    always @(posedge i_clk) begin
        cycles = cycles + 1;
        if (cycles > TIMEOUT_CYCLES) begin
            stop_run($sformatf("Timeout: run still busy after %0d cycles.", cycles));
        end
        if (i_rst) begin
            i_mem_credit <= 1'b0;
        end else if (credit_due.size() != 0 && credit_due[0] <= cycles) begin
            void'(credit_due.pop_front());
            i_mem_credit <= 1'b1;
        end else begin
            i_mem_credit <= 1'b0;
        end
    end

    // Mid-cycle monitor of credits and the memory port.
    always @(negedge i_clk) begin
        req_case_t want;
        if (!i_rst) begin
            if (o_if_credit) begin
                if_credits++;
            end
            if (o_d_credit) begin
                d_credits++;
            end
            if (if_credits > FIFO_DEPTH || d_credits > FIFO_DEPTH) begin
                stop_run("A sender got back more credits than it spent.");
            end
            if (o_mem_valid) begin
                if (mem_credits == 0) begin
                    stop_run("Memory request issued with no memory credit left.");
                end
                mem_credits--;
                credit_due.push_back(cycles + int'($urandom % 4));
                if (o_mem_is_fetch) begin
                    if (if_exp_q.size() == 0) begin
                        stop_run("Fetch on the memory port that was never requested.");
                    end
                    want = if_exp_q.pop_front();
                end else begin
                    if (d_exp_q.size() == 0) begin
                        stop_run("Data access on the memory port that was never requested.");
                    end
                    want = d_exp_q.pop_front();
                end
                check_paddr(o_mem_addr, want.exp_paddr, "memory address");
                check_bit(o_mem_cacheable, want.exp_cacheable, "cacheable flag");
                check_bit(o_mem_we, want.we, "write flag");
                if (!want.is_fetch) begin
                    check_word(o_mem_wdata, want.wdata, "write data");
                end
            end
            // The DUT sees a returned credit one edge later, so it counts after the valid check.
            if (i_mem_credit) begin
                mem_credits++;
            end
        end
    end

    initial begin
        void'($urandom(SEED));
        i_rst      = 1'b1;
        i_if_valid = 1'b0;
        i_if_addr  = '0;
        i_d_valid  = 1'b0;
        i_d_addr   = '0;
        i_d_we     = 1'b0;
        i_d_wdata  = '0;
        i_sr_addr  = '0;
        i_sr_data  = '0;
        i_sr_we    = 1'b0;
        i_pag_en   = 1'b0;
        repeat (RESET_CYCLES) @(posedge i_clk);
        i_rst <= 1'b0;
        @(negedge i_clk);
        check_bit(o_mem_valid, 1'b0, "memory valid after reset");
        check_bit(o_if_credit, 1'b0, "fetch credit after reset");
        check_bit(o_d_credit, 1'b0, "data credit after reset");
        for (int i = 0; i < N_REQ; i++) begin
            if (i == LOAD_AT) begin
                drain();
                foreach (sr_writes[j]) begin
                    write_sr(sr_writes[j]);
                end
            end
            // Paging applies at the queue head, so the queues must be empty first.
            if (req_cases[i].pag_en !== i_pag_en) begin
                drain();
                next_edge();
                i_pag_en <= req_cases[i].pag_en;
            end
            send_req(req_cases[i]);
        end
        settle();
        if (if_credits == FIFO_DEPTH && d_credits == FIFO_DEPTH) begin
            $display("Everything OK");
            $finish;
        end else begin
            stop_run("A sender is still missing credits at the end of the run.");
        end
    end

endmodule

// ==== sim.f ====
+incdir+dv
verilog/mmu_pkg.sv
verilog/credit_fifo.sv
verilog/page_mmu.sv
verilog/mem_arbiter.sv
verilog/mmu_top.sv
dv/tb_mmu_top.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = tb_mmu_top
FILELIST  = sim.f
OBJ_DIR   = obj_dir
PASS_MSG  = Everything OK

.PHONY: sim clean

# Build, run, and pass only when the pass message shows up in the output.
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
